/* verilog/frame_consts.svh */
// Frame transmit constants
// Widths and depths shared by the data path, the frame addressing and
// the host memory channel of the frame transmit subsystem

`ifndef FRAME_CONSTS_SVH
`define FRAME_CONSTS_SVH

// Buffer entries, which is also the credit count the sender starts with
`define FIFO_DEPTH 16

// Width of one stream word and of one host cache line payload
`define DATA_W 128

// A frame holds 2**CHUNK_LOG lines, chunk 0 being the header/control line
`define CHUNK_LOG 4

// The ring holds 2**FRAME_LOG frames
`define FRAME_LOG 3

// Width of a host line address
`define ADDR_W 32

// Quiet cycles after which a partly filled frame is closed
`define IDLE_LIMIT 15

`endif

/* verilog/frame_types_pkg.sv */
// Frame data-path types
// Stream word, buffer pointer and the pieces of a frame line address
// (ring base, frame number, chunk index)

`default_nettype none

`include "frame_consts.svh"

package frame_types_pkg;

   // One word of the incoming stream, written as one line
   typedef logic [`DATA_W-1:0] data_word_t;

   // Line position inside a frame
   typedef logic [`CHUNK_LOG-1:0] chunk_idx_t;

   // Frame position inside the ring
   typedef logic [`FRAME_LOG-1:0] frame_num_t;

   // Upper address bits that locate the ring in host memory
   typedef logic [`ADDR_W-`CHUNK_LOG-`FRAME_LOG-1:0] base_ptr_t;

   // Buffer pointer with one extra wrap bit to tell full from empty
   typedef logic [$clog2(`FIFO_DEPTH):0] fifo_ptr_t;

   // Chunk 0 holds header and control, so data starts at chunk 1
   localparam chunk_idx_t first_data_chunk = chunk_idx_t'(1);

   // Last line of a frame; granting it fills the frame
   localparam chunk_idx_t last_chunk = '1;

endpackage

`default_nettype wire

/* verilog/mem_chan_pkg.sv */
// Host memory channel types
// Line address, write request kinds and the layout of the header word
// read from chunk 0 and of the control word written back to it

`default_nettype none

`include "frame_consts.svh"

package mem_chan_pkg;

   typedef logic [`ADDR_W-1:0] line_addr_t;

   // A write is either a data/control line or an ordering fence
   typedef enum logic {wr_line, wr_fence} wr_kind_t;

   typedef logic [`DATA_W-1:0] ctrl_word_t;
   typedef logic [`DATA_W-1:0] header_word_t;

   // Fixed marker software looks for in the top 32 bits of a control word
   localparam logic [31:0] ctrl_marker = 32'hdeadbeef;

   // Control word: marker on top, line count in bits 4:1, valid in bit 0
   function automatic ctrl_word_t make_ctrl_word(input logic [3:0] line_count);
      ctrl_word_t word;
      word = '0;
      word[`DATA_W-1 -: 32] = ctrl_marker;
      word[4:1] = line_count;
      word[0] = 1'b1;
      return word;
   endfunction

   // Software sets bit 0 while it still owns the frame
   function automatic logic header_in_use(input header_word_t hdr);
      return hdr[0];
   endfunction

endpackage

`default_nettype wire

/* verilog/data_credit_fifo.sv */
// Credit based input buffer
// Circular buffer for incoming stream words. The sender holds the credits;
// each word that leaves the buffer hands one credit back with a single
// cycle pulse on credit_return

`default_nettype none

`include "frame_consts.svh"

module data_credit_fifo
(
   input  wire logic                      clk,
   input  wire logic                      rst_n,

   // Write side, driven by the sender
   input  wire logic                      push,
   input  wire frame_types_pkg::data_word_t push_data,

   // Read side, toward the frame writer
   input  wire logic                      pop,
   output logic                           valid,
   output frame_types_pkg::data_word_t    head_data,

   // One pulse per word popped
   output logic                           credit_return
);

   import frame_types_pkg::*;

   // Index width is the pointer width without its wrap bit
   localparam int idx_w = $bits(fifo_ptr_t) - 1;

   // ======================================================================
   // Storage and pointers
   // ======================================================================

   // Payload storage, one stream word per entry
   data_word_t mem [`FIFO_DEPTH];

   fifo_ptr_t wr_ptr;
   fifo_ptr_t rd_ptr;

   logic full;
   logic do_push;
   logic do_pop;

   // Empty when the pointers match, wrap bit included
   assign valid = (wr_ptr != rd_ptr);

   // Full when the index bits match and the wrap bits differ
   assign full = (wr_ptr[idx_w-1:0] == rd_ptr[idx_w-1:0]) &&
                 (wr_ptr[idx_w] != rd_ptr[idx_w]);

   // Credits keep the sender from pushing into a full buffer
   // A push that finds the buffer full is dropped
   assign do_push = push && !full;
   assign do_pop  = pop && valid;

   // The head word is read straight from the entry under the read pointer
   assign head_data = mem[rd_ptr[idx_w-1:0]];

   always_ff @(posedge clk)
   begin
      if (do_push)
      begin
         mem[wr_ptr[idx_w-1:0]] <= push_data;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         // A word pushed at this edge shows on valid right after it
         if (do_push)
         begin
            wr_ptr <= wr_ptr + fifo_ptr_t'(1);
         end
         if (do_pop)
         begin
            rd_ptr <= rd_ptr + fifo_ptr_t'(1);
         end
      end
   end

   // ======================================================================
   // Credit return
   // ======================================================================

   // The pulse follows the edge that retires the word, so the sender
   // never sees a credit for an entry that is still occupied
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         credit_return <= 1'b0;
      end
      else
      begin
         credit_return <= do_pop;
      end
   end

endmodule

`default_nettype wire

/* verilog/frame_writer.sv */
// Frame writer
// Walks the ring of frames in host memory. For each frame it polls the
// header until software has released the frame, writes buffered words
// into chunks 1 and up, then closes the frame with a write fence and a
// control word in chunk 0. A frame closes when full or after a quiet
// period once it holds data

`default_nettype none

`include "frame_consts.svh"

module frame_writer
(
   input  wire logic                         clk,
   input  wire logic                         rst_n,

   input  wire logic                         enable,
   input  wire frame_types_pkg::base_ptr_t   frame_base,

   // Buffer head
   input  wire logic                         fifo_valid,
   input  wire frame_types_pkg::data_word_t  fifo_data,
   output logic                              fifo_pop,

   // Header reads
   output logic                              rd_req,
   output mem_chan_pkg::line_addr_t          rd_addr,
   input  wire logic                         rd_grant,
   input  wire logic                         rd_rsp_valid,
   input  wire mem_chan_pkg::header_word_t   rd_rsp_data,

   // Data, fence and control writes
   output logic                              wr_req,
   output mem_chan_pkg::wr_kind_t            wr_kind,
   output mem_chan_pkg::line_addr_t          wr_addr,
   output frame_types_pkg::data_word_t       wr_data,
   input  wire logic                         wr_grant
);

   import frame_types_pkg::*;
   import mem_chan_pkg::*;

   typedef enum logic [2:0]
   {
      st_idle,
      st_poll_header,
      st_wait_header,
      st_write_data,
      st_write_fence,
      st_write_control
   } writer_state_t;

   writer_state_t state;
   writer_state_t next_state;

   frame_num_t frame_num;
   chunk_idx_t chunk_idx;
   logic [3:0] idle_cnt;

   logic data_write_ok;
   logic frame_full;
   logic idle_close;

   // ======================================================================
   // Frame close conditions
   // ======================================================================

   // A data line retires on its grant and pops the buffer in that cycle
   assign data_write_ok = (state == st_write_data) && fifo_valid && wr_grant;
   assign fifo_pop      = data_write_ok;

   // Granting the last chunk fills the frame. The chunk index then wraps
   // to 0, so chunk_idx - 1 still gives the 15 lines for the control word
   assign frame_full = data_write_ok && (chunk_idx == last_chunk);

   // Quiet close only when nothing is waiting, so a pending grant is
   // never dropped, and only if the frame already holds a line
   assign idle_close = (idle_cnt == 4'(`IDLE_LIMIT)) && !fifo_valid &&
                       (chunk_idx > first_data_chunk);

   // ======================================================================
   // State machine
   // ======================================================================

   always_comb
   begin
      next_state = state;
      case (state)
         st_idle:
         begin
            next_state = st_poll_header;
         end
         st_poll_header:
         begin
            if (rd_grant)
            begin
               next_state = st_wait_header;
            end
         end
         st_wait_header:
         begin
            // Software still owns the frame, so ask again for the same one
            if (rd_rsp_valid)
            begin
               next_state = header_in_use(rd_rsp_data) ? st_poll_header : st_write_data;
            end
         end
         st_write_data:
         begin
            if (frame_full || idle_close)
            begin
               next_state = st_write_fence;
            end
         end
         st_write_fence:
         begin
            if (wr_grant)
            begin
               next_state = st_write_control;
            end
         end
         st_write_control:
         begin
            if (wr_grant)
            begin
               next_state = st_poll_header;
            end
         end
         default:
         begin
            next_state = st_idle;
         end
      endcase

      // Disabling parks the writer in idle
      if (!enable)
      begin
         next_state = st_idle;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state <= st_idle;
      end
      else
      begin
         state <= next_state;
      end
   end

   // ======================================================================
   // Frame position and idle counter
   // ======================================================================

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         frame_num <= '0;
         chunk_idx <= first_data_chunk;
         idle_cnt  <= '0;
      end
      else
      begin
         // The ring restarts at frame 0 whenever the writer passes idle
         if (state == st_idle)
         begin
            frame_num <= '0;
         end
         else if ((state == st_write_control) && wr_grant)
         begin
            frame_num <= frame_num + frame_num_t'(1);
         end

         if (state == st_poll_header)
         begin
            chunk_idx <= first_data_chunk;
         end
         else if (data_write_ok)
         begin
            chunk_idx <= chunk_idx + chunk_idx_t'(1);
         end

         // Counts quiet cycles and holds at the limit
         if (fifo_valid)
         begin
            idle_cnt <= '0;
         end
         else if (idle_cnt != 4'(`IDLE_LIMIT))
         begin
            idle_cnt <= idle_cnt + 4'd1;
         end
      end
   end

   // ======================================================================
   // Memory requests
   // ======================================================================

   // Header lives in chunk 0 of the current frame
   assign rd_req  = (state == st_poll_header);
   assign rd_addr = {frame_base, frame_num, chunk_idx_t'(0)};

   // All requests are built from registered state, so they stay put
   // until granted
   assign wr_req = ((state == st_write_data) && fifo_valid) ||
                   (state == st_write_fence) || (state == st_write_control);

   assign wr_kind = (state == st_write_fence) ? wr_fence : wr_line;

   always_comb
   begin
      case (state)
         st_write_fence:
         begin
            wr_addr = '0;
         end
         st_write_control:
         begin
            wr_addr = {frame_base, frame_num, chunk_idx_t'(0)};
         end
         default:
         begin
            wr_addr = {frame_base, frame_num, chunk_idx};
         end
      endcase
   end

   // Control word carries the number of data lines in the frame
   assign wr_data = (state == st_write_data) ? fifo_data :
                    make_ctrl_word(chunk_idx - chunk_idx_t'(1));

endmodule

`default_nettype wire

/* verilog/frame_tx_top.sv */
// Frame transmit top level
// Takes the credit flow controlled stream from the sender into the input
// buffer and lets the frame writer drain it into the host frame ring

`default_nettype none

module frame_tx_top
(
   input  wire logic                         clk,
   input  wire logic                         rst_n,

   // Sender side
   input  wire logic                         in_valid,
   input  wire frame_types_pkg::data_word_t  in_data,
   output logic                              credit_return,

   // Control
   input  wire logic                         enable,
   input  wire frame_types_pkg::base_ptr_t   frame_base,

   // Host memory read channel
   output logic                              rd_req,
   output mem_chan_pkg::line_addr_t          rd_addr,
   input  wire logic                         rd_grant,
   input  wire logic                         rd_rsp_valid,
   input  wire mem_chan_pkg::header_word_t   rd_rsp_data,

   // Host memory write channel
   output logic                              wr_req,
   output mem_chan_pkg::wr_kind_t            wr_kind,
   output mem_chan_pkg::line_addr_t          wr_addr,
   output frame_types_pkg::data_word_t       wr_data,
   input  wire logic                         wr_grant
);

   import frame_types_pkg::*;

   // Buffer head as seen by the writer
   logic       fifo_valid;
   data_word_t fifo_data;
   logic       fifo_pop;

   data_credit_fifo i_fifo
   (
      .clk           (clk),
      .rst_n         (rst_n),
      .push          (in_valid),
      .push_data     (in_data),
      .pop           (fifo_pop),
      .valid         (fifo_valid),
      .head_data     (fifo_data),
      .credit_return (credit_return)
   );

   frame_writer i_writer
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .enable       (enable),
      .frame_base   (frame_base),
      .fifo_valid   (fifo_valid),
      .fifo_data    (fifo_data),
      .fifo_pop     (fifo_pop),
      .rd_req       (rd_req),
      .rd_addr      (rd_addr),
      .rd_grant     (rd_grant),
      .rd_rsp_valid (rd_rsp_valid),
      .rd_rsp_data  (rd_rsp_data),
      .wr_req       (wr_req),
      .wr_kind      (wr_kind),
      .wr_addr      (wr_addr),
      .wr_data      (wr_data),
      .wr_grant     (wr_grant)
   );

endmodule

`default_nettype wire

/* verification/mem_host_model.sv */
// Host memory responder
// Plays the host side of the frame writer's memory channel. It grants reads
// and writes at random and answers header reads after 1 to 4 cycles. It
// records every granted write in order, so the testbench can rebuild the
// frame contents and check them

`default_nettype none

`include "frame_consts.svh"

module mem_host_model
(
   input  wire logic                         clk,
   input  wire logic                         rst_n,

   // Header reads
   input  wire logic                         rd_req,
   output logic                              rd_grant,
   output logic                              rd_rsp_valid,
   output mem_chan_pkg::header_word_t        rd_rsp_data,

   // Data, fence and control writes
   input  wire logic                         wr_req,
   input  wire mem_chan_pkg::wr_kind_t       wr_kind,
   input  wire mem_chan_pkg::line_addr_t     wr_addr,
   input  wire frame_types_pkg::data_word_t  wr_data,
   output logic                              wr_grant
);

   timeunit 1ns;
   timeprecision 1ps;

   import frame_types_pkg::*;
   import mem_chan_pkg::*;

   integer seed;

   // Granted writes in the order the host accepted them
   wr_kind_t   kind_q[$];
   line_addr_t addr_q[$];
   data_word_t data_q[$];
   // In-use flag of the latest header response at the time of each write
   logic       busy_q[$];

   int           rsp_wait;
   logic         rsp_busy;
   logic         first_poll;
   logic         last_busy;
   header_word_t hdr;

   initial
   begin
      seed         = 92165;
      rd_grant     = 1'b0;
      wr_grant     = 1'b0;
      rd_rsp_valid = 1'b0;
      rd_rsp_data  = '0;
      rsp_wait     = 0;
      rsp_busy     = 1'b0;
      first_poll   = 1'b1;
      last_busy    = 1'b0;
      forever
      begin
         // Requests and grants have both settled by the falling edge
         @(negedge clk);
         if (rst_n && rd_req && rd_grant)
         begin
            rsp_wait = 1 + int'($unsigned($random(seed)) % 4);
            // Only the first poll of a frame may find software still holding it
            rsp_busy   = first_poll && (($random(seed) & 1) != 0);
            first_poll = 1'b0;
         end
         if (rst_n && wr_req && wr_grant)
         begin
            kind_q.push_back(wr_kind);
            addr_q.push_back(wr_addr);
            data_q.push_back(wr_data);
            busy_q.push_back(last_busy);
            // A control line in chunk 0 closes the frame, so the next poll is a first poll
            if ((wr_kind == wr_line) && (wr_addr[`CHUNK_LOG-1:0] == '0))
            begin
               first_poll = 1'b1;
            end
         end

         @(posedge clk);
         #2;
         rd_rsp_valid = 1'b0;
         if (rsp_wait > 0)
         begin
            rsp_wait--;
            if (rsp_wait == 0)
            begin
               hdr          = {$random(seed), $random(seed), $random(seed), $random(seed)};
               hdr[0]       = rsp_busy;
               rd_rsp_data  = hdr;
               rd_rsp_valid = 1'b1;
               last_busy    = rsp_busy;
            end
         end
         // Each channel is granted in about three cycles out of four
         rd_grant = (($random(seed) & 3) != 0);
         wr_grant = (($random(seed) & 3) != 0);
      end
   end

endmodule

`default_nettype wire

/* verification/frame_tx_tb.sv */
// Frame transmit testbench
// Feeds random bursts of words through a credit respecting sender and lets
// the host model grant and answer at random. Every granted write is checked
// against a model of the frame ring that is kept here

`default_nettype none

`include "frame_consts.svh"

module frame_tx_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import frame_types_pkg::*;
   import mem_chan_pkg::*;

   localparam int num_words   = 300;
   localparam int max_lines   = (1 << `CHUNK_LOG) - 1;
   localparam int cycle_limit = 40 * num_words + 2000;

   logic         clk;
   logic         rst_n;
   logic         in_valid;
   data_word_t   in_data;
   logic         credit_return;
   logic         enable;
   base_ptr_t    frame_base;
   logic         rd_req;
   line_addr_t   rd_addr;
   logic         rd_grant;
   logic         rd_rsp_valid;
   header_word_t rd_rsp_data;
   logic         wr_req;
   wr_kind_t     wr_kind;
   line_addr_t   wr_addr;
   data_word_t   wr_data;
   logic         wr_grant;

   integer     seed;
   // Words sent and not yet seen in a granted data write
   data_word_t sent_q[$];
   int         sent_cnt;
   int         credits;
   int         return_cnt;
   int         line_writes;
   int         line_cnt;
   int         cycle_cnt;
   frame_num_t exp_frame;
   logic       fence_open;
   int         word_errs;
   int         addr_errs;
   int         ctrl_errs;
   int         other_errs;

   frame_tx_top i_frame_tx_top
   (
      .clk           (clk),
      .rst_n         (rst_n),
      .in_valid      (in_valid),
      .in_data       (in_data),
      .credit_return (credit_return),
      .enable        (enable),
      .frame_base    (frame_base),
      .rd_req        (rd_req),
      .rd_addr       (rd_addr),
      .rd_grant      (rd_grant),
      .rd_rsp_valid  (rd_rsp_valid),
      .rd_rsp_data   (rd_rsp_data),
      .wr_req        (wr_req),
      .wr_kind       (wr_kind),
      .wr_addr       (wr_addr),
      .wr_data       (wr_data),
      .wr_grant      (wr_grant)
   );

   mem_host_model i_host
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .rd_req       (rd_req),
      .rd_grant     (rd_grant),
      .rd_rsp_valid (rd_rsp_valid),
      .rd_rsp_data  (rd_rsp_data),
      .wr_req       (wr_req),
      .wr_kind      (wr_kind),
      .wr_addr      (wr_addr),
      .wr_data      (wr_data),
      .wr_grant     (wr_grant)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // ====================================================================
   // Compare tasks
   // ====================================================================

   task automatic check_word(input string name, input data_word_t got, input data_word_t exp);
      if (got !== exp)
      begin
         word_errs++;
         $display("error: %s = %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_addr(input string name, input line_addr_t got, input line_addr_t exp);
      if (got !== exp)
      begin
         addr_errs++;
         $display("error: %s = %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_ctrl(input string name, input ctrl_word_t got, input ctrl_word_t exp);
      if (got !== exp)
      begin
         ctrl_errs++;
         $display("error: %s = %h, expected %h", name, got, exp);
      end
   endtask

   task automatic report_fault(input string what);
      other_errs++;
      $display("At %0t ns: %s", $time, what);
   endtask

   // ====================================================================
   // Frame ring model
   // ====================================================================

   // Takes the oldest granted write from the host and checks it against
   // the frame that should be open right now
   task automatic process_write();
      wr_kind_t   kind;
      line_addr_t addr;
      data_word_t data;
      logic       busy;
      ctrl_word_t exp_ctrl;
      kind = i_host.kind_q.pop_front();
      addr = i_host.addr_q.pop_front();
      data = i_host.data_q.pop_front();
      busy = i_host.busy_q.pop_front();
      if (kind == wr_fence)
      begin
         if (fence_open || (line_cnt == 0))
         begin
            report_fault("Fence written with no filled frame waiting to close");
         end
         check_addr("wr_addr", addr, '0);
         fence_open = 1'b1;
      end
      else if (addr[`CHUNK_LOG-1:0] == chunk_idx_t'(0))
      begin
         if (!fence_open)
         begin
            report_fault("Control word written without a fence before it");
         end
         check_addr("wr_addr", addr, {frame_base, exp_frame, chunk_idx_t'(0)});
         // Marker on top, line count in 4:1, valid flag in bit 0
         exp_ctrl = '0;
         exp_ctrl[`DATA_W-1 -: 32] = ctrl_marker;
         exp_ctrl[4:1] = 4'(line_cnt);
         exp_ctrl[0] = 1'b1;
         check_ctrl("wr_data", data, exp_ctrl);
         exp_frame  = exp_frame + frame_num_t'(1);
         line_cnt   = 0;
         fence_open = 1'b0;
      end
      else
      begin
         if (fence_open)
         begin
            report_fault("Data line written between a fence and its control word");
         end
         if (busy)
         begin
            report_fault("Data line written to a frame that software still holds");
         end
         if (line_cnt == max_lines)
         begin
            report_fault("Frame holds more data lines than fit in it");
         end
         if (sent_q.size() == 0)
         begin
            report_fault("Data line written with no word left to send");
         end
         else
         begin
            check_word("wr_data", data, sent_q.pop_front());
         end
         check_addr("wr_addr", addr, {frame_base, exp_frame, chunk_idx_t'(line_cnt + 1)});
         line_cnt++;
         line_writes++;
      end
   endtask

   // Writes are recorded at the falling edge and consumed at the next rising one
   always @(posedge clk)
   begin
      while (i_host.kind_q.size() != 0)
      begin
         process_write();
      end
   end

   // Header reads go to chunk 0 of the frame the ring model expects next
   always @(negedge clk)
   begin
      if (rst_n && rd_req && rd_grant)
      begin
         check_addr("rd_addr", rd_addr, {frame_base, exp_frame, chunk_idx_t'(0)});
      end
   end

   always @(negedge clk)
   begin
      if (rst_n && credit_return)
      begin
         credits++;
         return_cnt++;
         if (credits > `FIFO_DEPTH)
         begin
            report_fault("Sender received more credits than the buffer holds");
         end
      end
   end

   // ====================================================================
   // Sender
   // ====================================================================

   task automatic run_sender(input int total);
      int burst;
      int gap;
      burst = 1 + int'($unsigned($random(seed)) % 24);
      gap   = 0;
      while (sent_cnt < total)
      begin
         @(posedge clk);
         #2;
         in_valid = 1'b0;
         if (gap > 0)
         begin
            gap--;
         end
         else if ((credits > 0) && (($random(seed) & 3) != 0))
         begin
            in_data  = {$random(seed), $random(seed), $random(seed), $random(seed)};
            in_valid = 1'b1;
            credits--;
            sent_q.push_back(in_data);
            sent_cnt++;
            burst--;
            if (burst == 0)
            begin
               burst = 1 + int'($unsigned($random(seed)) % 24);
               // Half the gaps are long enough to close a partly filled frame
               if (($random(seed) & 1) != 0)
               begin
                  gap = `IDLE_LIMIT + 2 + int'($unsigned($random(seed)) % 16);
               end
               else
               begin
                  gap = int'($unsigned($random(seed)) % 4);
               end
            end
         end
      end
      @(posedge clk);
      #2;
      in_valid = 1'b0;
   endtask

   task automatic print_counts();
      $display("Error counts: word %0d, address %0d, control %0d, other %0d",
               word_errs, addr_errs, ctrl_errs, other_errs);
   endtask

   // ====================================================================
   // Main sequence and timeout
   // ====================================================================

   initial
   begin
      seed        = 92165;
      rst_n       = 1'b0;
      in_valid    = 1'b0;
      in_data     = '0;
      enable      = 1'b0;
      frame_base  = '0;
      sent_cnt    = 0;
      credits     = `FIFO_DEPTH;
      return_cnt  = 0;
      line_writes = 0;
      line_cnt    = 0;
      exp_frame   = '0;
      fence_open  = 1'b0;
      word_errs   = 0;
      addr_errs   = 0;
      ctrl_errs   = 0;
      other_errs  = 0;
      repeat (3) @(posedge clk);
      #2;
      rst_n      = 1'b1;
      frame_base = base_ptr_t'($random(seed));
      enable     = 1'b1;

      run_sender(num_words);

      // Drained once every word is written, the last frame is closed and
      // all credits are back with the sender
      while ((sent_q.size() != 0) || (line_cnt != 0) || fence_open ||
             (credits != `FIFO_DEPTH))
      begin
         @(posedge clk);
         #2;
      end
      if (return_cnt != line_writes)
      begin
         report_fault($sformatf("Saw %0d credit pulses for %0d granted data writes",
                                return_cnt, line_writes));
      end

      print_counts();
      if ((word_errs + addr_errs + ctrl_errs + other_errs) == 0)
      begin
         $display("All tests passed!");
      end
      else
      begin
         $display("Test failures found");
      end
      $finish;
   end

   initial
   begin
      cycle_cnt = 0;
      while (cycle_cnt < cycle_limit)
      begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout after %0d cycles with %0d words not yet written",
               cycle_cnt, sent_q.size());
      print_counts();
      $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

/* src.f */
+incdir+verilog
verilog/frame_types_pkg.sv
verilog/mem_chan_pkg.sv
verilog/data_credit_fifo.sv
verilog/frame_writer.sv
verilog/frame_tx_top.sv
verification/mem_host_model.sv
verification/frame_tx_tb.sv

/* Makefile */
# Verilator build and run of the frame transmit testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

obj_dir/frame_tx_sim: src.f $(wildcard verilog/*.sv verilog/*.svh verification/*.sv)
	verilator --binary --timing --timescale 1ns/1ps -f src.f \
		--top-module frame_tx_tb -o frame_tx_sim

test: obj_dir/frame_tx_sim
	./obj_dir/frame_tx_sim > sim.log 2>&1; cat sim.log
	@if grep -q "Test failures found" sim.log; then \
		echo "Simulation FAILED"; exit 1; \
	elif ! grep -q "All tests passed!" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf obj_dir sim.log
